// ==== rtl/dot_defs.svh ====
//////////////////////////////////////////////////
// Dot-product peripheral constants
// Element, accumulator and length widths
// Wishbone widths and register word addresses
//////////////////////////////////////////////////

`ifndef DOT_DEFS_SVH
`define DOT_DEFS_SVH

// Datapath widths
`define DOT_ELEM_W 16
`define DOT_ACC_W  32
`define DOT_LEN_W  12

// Wishbone port widths
`define DOT_WB_AW 4
`define DOT_WB_DW 32

// Register map, byte address of each 32-bit word
`define DOT_REG_CTRL   4'h0
`define DOT_REG_ELEM   4'h4
`define DOT_REG_STATUS 4'h8
`define DOT_REG_RESULT 4'hC

`endif

// ==== rtl/dot_pkg.sv ====
//////////////////////////////////////////////////
// Shared types of the dot-product peripheral
// Element pair, lane request, lane state, result
//////////////////////////////////////////////////

`default_nettype none

`include "dot_defs.svh"

package dot_pkg;

  // One ELEM write word, a in the low half
  typedef struct packed {
    logic signed [`DOT_ELEM_W-1:0] b;
    logic signed [`DOT_ELEM_W-1:0] a;
  } elem_pair_t;

  // Request word into one MAC lane
  typedef struct packed {
    logic       valid;
    logic       clear;
    elem_pair_t pair;
  } lane_req_t;

  // Lane state seen by the combiner
  typedef struct packed {
    logic                         busy;
    logic signed [`DOT_ACC_W-1:0] psum;
  } lane_out_t;

  // Final result, held until next start
  typedef struct packed {
    logic                  done;
    logic [`DOT_ACC_W-1:0] sum;
  } dot_result_t;

endpackage

`default_nettype wire

// ==== rtl/dot_wb_regs.sv ====
//////////////////////////////////////////////////
// Wishbone classic slave of the dot-product unit
// Single-cycle ACK, CTRL/ELEM/STATUS/RESULT map
// Length and element count registers
// Even/odd dispatch of element pairs to the lanes
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dot_defs.svh"

module dot_wb_regs (
  input  logic                  CLK,
  input  logic                  RST,
  // Wishbone slave
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`DOT_WB_AW-1:0] adr,
  input  logic [`DOT_WB_DW-1:0] dat_i,
  input  logic [3:0]            sel,
  output logic [`DOT_WB_DW-1:0] dat_o,
  output logic                  ack,
  // Lane side
  output dot_pkg::lane_req_t    lane_req_even,
  output dot_pkg::lane_req_t    lane_req_odd,
  output logic                  all_issued,
  output logic                  start_pulse,
  input  dot_pkg::dot_result_t  result
);

  // Start flag in the top byte of CTRL
  localparam int START_BIT = 31;

  logic                  bus_req;
  logic                  wr_cyc;
  logic [`DOT_WB_DW-1:0] wdata;
  logic                  ctrl_wr;
  logic                  elem_wr;
  logic                  start_wr;
  logic                  elem_take;
  logic [`DOT_LEN_W-1:0] len_q;
  logic [`DOT_LEN_W-1:0] count_q;
  logic                  armed_q;
  dot_pkg::elem_pair_t   pair_in;
  logic [`DOT_WB_DW-1:0] status_word;

  //////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////

  // New access, first cycle of STB only
  assign bus_req = cyc & stb & ~ack;
  // Writes take effect in the ACK cycle
  assign wr_cyc  = cyc & stb & we & ack;

  // Byte enables, disabled bytes read as zero
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wdata[8*i +: 8] = sel[i] ? dat_i[8*i +: 8] : 8'h00;
    end
  end

  assign ctrl_wr   = wr_cyc & (adr == `DOT_REG_CTRL);
  assign elem_wr   = wr_cyc & (adr == `DOT_REG_ELEM);
  assign start_wr  = ctrl_wr & wdata[START_BIT];
  // Extra pairs past the length are dropped
  assign elem_take = elem_wr & (count_q < len_q);
  assign pair_in   = dot_pkg::elem_pair_t'(wdata);

  // STATUS layout: done in bit 0, count from bit 16
  always_comb begin
    status_word                   = '0;
    status_word[0]                = result.done;
    status_word[16 +: `DOT_LEN_W] = count_q;
  end

  //////////////////////////////////////////////////
  // ACK and read data
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ack   <= 1'b0;
      dat_o <= '0;
    end else begin
      // One ACK per access, never back to back
      ack <= bus_req;
      if (bus_req && !we) begin
        case (adr)
          `DOT_REG_STATUS: dat_o <= status_word;
          `DOT_REG_RESULT: dat_o <= result.sum;
          default:         dat_o <= '0;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Length, count and completion flag
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      len_q       <= '0;
      count_q     <= '0;
      armed_q     <= 1'b0;
      start_pulse <= 1'b0;
      all_issued  <= 1'b0;
    end else begin
      start_pulse <= start_wr;
      // Registered so lane busy has time to rise
      all_issued  <= armed_q & (count_q == len_q);
      if (start_wr) begin
        len_q   <= wdata[`DOT_LEN_W-1:0];
        count_q <= '0;
        armed_q <= 1'b1;
      end else if (elem_take) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Lane dispatch by count parity
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      lane_req_even <= '0;
      lane_req_odd  <= '0;
    end else begin
      lane_req_even.valid <= elem_take & ~count_q[0];
      lane_req_odd.valid  <= elem_take & count_q[0];
      // Clear goes to both lanes at once
      lane_req_even.clear <= start_wr;
      lane_req_odd.clear  <= start_wr;
      if (elem_take && !count_q[0]) begin
        lane_req_even.pair <= pair_in;
      end
      if (elem_take && count_q[0]) begin
        lane_req_odd.pair <= pair_in;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dot_mac_lane.sv ====
//////////////////////////////////////////////////
// Two-stage signed multiply-accumulate lane
// Stage 1 product, stage 2 wrapping partial sum
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dot_defs.svh"

module dot_mac_lane (
  input  logic               CLK,
  input  logic               RST,
  input  dot_pkg::lane_req_t req,
  output dot_pkg::lane_out_t lane
);

  localparam int PROD_W = 2 * `DOT_ELEM_W;

  logic                         s1_valid;
  logic signed [PROD_W-1:0]     s1_prod;
  logic                         s2_valid;
  logic signed [`DOT_ACC_W-1:0] prod_ext;
  logic signed [`DOT_ACC_W-1:0] psum_q;

  //////////////////////////////////////////////////
  // Stage 1, product register
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else if (req.clear) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req.valid;
    end
  end

  // Full-width signed product, no overflow
  always_ff @(posedge CLK) begin
    if (req.clear) begin
      s1_prod <= '0;
    end else if (req.valid) begin
      s1_prod <= req.pair.a * req.pair.b;
    end
  end

  //////////////////////////////////////////////////
  // Stage 2, accumulate
  //////////////////////////////////////////////////

  // Sign extension to accumulator width
  assign prod_ext = s1_prod;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s2_valid <= 1'b0;
      psum_q   <= '0;
    end else if (req.clear) begin
      s2_valid <= 1'b0;
      psum_q   <= '0;
    end else begin
      s2_valid <= s1_valid;
      // Wraps modulo 2^32
      if (s1_valid) begin
        psum_q <= psum_q + prod_ext;
      end
    end
  end

  // Busy while anything sits in either stage
  assign lane.busy = s1_valid | s2_valid;
  assign lane.psum = psum_q;

endmodule

`default_nettype wire

// ==== rtl/dot_combiner.sv ====
//////////////////////////////////////////////////
// Completion detect and final sum of both lanes
// Result and done held until the next start
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dot_defs.svh"

module dot_combiner (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start_pulse,
  input  logic                 all_issued,
  input  dot_pkg::lane_out_t   lane_even,
  input  dot_pkg::lane_out_t   lane_odd,
  output dot_pkg::dot_result_t result
);

  logic                  lanes_idle;
  logic                  drain_done;
  logic [`DOT_ACC_W-1:0] sum_next;

  //////////////////////////////////////////////////
  // Completion condition
  //////////////////////////////////////////////////

  // Both pipelines empty
  assign lanes_idle = ~lane_even.busy & ~lane_odd.busy;

  // All pairs issued and drained, first time only
  assign drain_done = all_issued & lanes_idle & ~result.done;

  // Partial sums added with 32-bit wraparound
  assign sum_next = lane_even.psum + lane_odd.psum;

  //////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result <= '0;
    end else if (start_pulse) begin
      // New run, drop the old result
      result <= '0;
    end else if (drain_done) begin
      result.done <= 1'b1;
      result.sum  <= sum_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dot_top.sv ====
//////////////////////////////////////////////////
// Top of the dot-product peripheral
// Register block, even and odd MAC lanes, combiner
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dot_defs.svh"

module dot_top (
  input  logic                  CLK,
  input  logic                  RST,
  // Wishbone classic slave
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`DOT_WB_AW-1:0] adr,
  input  logic [`DOT_WB_DW-1:0] dat_i,
  input  logic [3:0]            sel,
  output logic [`DOT_WB_DW-1:0] dat_o,
  output logic                  ack
);

  //////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////

  dot_pkg::lane_req_t   req_even;
  dot_pkg::lane_req_t   req_odd;
  dot_pkg::lane_out_t   out_even;
  dot_pkg::lane_out_t   out_odd;
  dot_pkg::dot_result_t result;
  logic                 all_issued;
  logic                 start_pulse;

  // Bus side and element dispatch
  dot_wb_regs regs (
    .CLK          (CLK),
    .RST          (RST),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .dat_i        (dat_i),
    .sel          (sel),
    .dat_o        (dat_o),
    .ack          (ack),
    .lane_req_even(req_even),
    .lane_req_odd (req_odd),
    .all_issued   (all_issued),
    .start_pulse  (start_pulse),
    .result       (result)
  );

  // Even element indices
  dot_mac_lane lane_even (
    .CLK (CLK),
    .RST (RST),
    .req (req_even),
    .lane(out_even)
  );

  // Odd element indices
  dot_mac_lane lane_odd (
    .CLK (CLK),
    .RST (RST),
    .req (req_odd),
    .lane(out_odd)
  );

  dot_combiner combiner (
    .CLK        (CLK),
    .RST        (RST),
    .start_pulse(start_pulse),
    .all_issued (all_issued),
    .lane_even  (out_even),
    .lane_odd   (out_odd),
    .result     (result)
  );

endmodule

`default_nettype wire

// ==== sim/dot_tb.sv ====
//////////////////////////////////////////////////
// Testbench of the dot-product peripheral
// Clock, reset and Wishbone host tasks
// Random vectors checked against a sum model
// Watchdog bounding the whole run
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dot_defs.svh"

module dot_tb;

  localparam int CLK_PERIOD = 8;
  localparam int MAX_LEN    = 64;
  localparam int NUM_RAND   = 40;
  // Random vectors plus the directed ones
  localparam int NUM_TESTS  = NUM_RAND + 12;
  localparam int TIMEOUT_NS = NUM_TESTS * (MAX_LEN + 20) * 4 * CLK_PERIOD;
  localparam int ACK_LIMIT  = 8;
  localparam int POLL_LIMIT = 64;
  // Start flag of CTRL
  localparam logic [31:0] START = 32'h8000_0000;

  logic                  CLK;
  logic                  RST;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [`DOT_WB_AW-1:0] adr;
  logic [`DOT_WB_DW-1:0] dat_i;
  logic [3:0]            sel;
  logic [`DOT_WB_DW-1:0] dat_o;
  logic                  ack;

  // Element storage of the vector under test
  logic [`DOT_ELEM_W-1:0] vec_a [MAX_LEN];
  logic [`DOT_ELEM_W-1:0] vec_b [MAX_LEN];

  dot_top UUT (
    .CLK  (CLK),
    .RST  (RST),
    .cyc  (cyc),
    .stb  (stb),
    .we   (we),
    .adr  (adr),
    .dat_i(dat_i),
    .sel  (sel),
    .dat_o(dat_o),
    .ack  (ack)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    stop_with_error($sformatf("Timeout, the run did not finish within %0d ns", TIMEOUT_NS));
  end

  //////////////////////////////////////////////////
  // Error reporting and checks
  //////////////////////////////////////////////////

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      stop_with_error($sformatf("CHECK FAILED at time %0t: %s expected 0x%08h, got 0x%08h",
                                $time, name, expected, actual));
    end
  endtask

  //////////////////////////////////////////////////
  // Wishbone host
  //////////////////////////////////////////////////

  task automatic wb_access(input logic write, input logic [`DOT_WB_AW-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    @(negedge CLK);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = addr;
    dat_i = wdata;
    sel   = 4'hF;
    // ACK looked at on falling edges only
    @(negedge CLK);
    waited = 1;
    while (!ack) begin
      assert (waited < ACK_LIMIT) else begin
        stop_with_error($sformatf("No Wishbone ACK for the access to address 0x%h", addr));
      end
      @(negedge CLK);
      waited++;
    end
    check_value("ack latency", 1, waited);
    rdata = dat_o;
    // Hold the access through the edge that ends ACK
    @(negedge CLK);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    // ACK lasts a single cycle
    check_value("ack", 0, ack);
  endtask

  task automatic wb_write(input logic [`DOT_WB_AW-1:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    wb_access(1'b1, addr, wdata, unused);
  endtask

  task automatic wb_read(input logic [`DOT_WB_AW-1:0] addr, output logic [31:0] rdata);
    wb_access(1'b0, addr, 32'h0, rdata);
  endtask

  //////////////////////////////////////////////////
  // Vector helpers and reference model
  //////////////////////////////////////////////////

  task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) begin
      vec_a[i] = 16'($urandom);
      vec_b[i] = 16'($urandom);
    end
  endtask

  task automatic start_vector(input int n);
    wb_write(`DOT_REG_CTRL, START | 32'(n));
  endtask

  task automatic send_elem(input int i);
    dot_pkg::elem_pair_t pair;
    pair.a = vec_a[i];
    pair.b = vec_b[i];
    wb_write(`DOT_REG_ELEM, pair);
  endtask

  // Sum of signed products, modulo 2^32
  function automatic logic [31:0] model_sum(input int n);
    logic signed [15:0] ea;
    logic signed [15:0] eb;
    logic signed [31:0] prod;
    logic [31:0]        acc;
    acc = '0;
    for (int i = 0; i < n; i++) begin
      ea   = vec_a[i];
      eb   = vec_b[i];
      prod = ea * eb;
      acc  = acc + prod;
    end
    return acc;
  endfunction

  task automatic wait_done(output logic [31:0] status);
    int polls;
    polls = 0;
    wb_read(`DOT_REG_STATUS, status);
    while (!status[0]) begin
      polls++;
      assert (polls < POLL_LIMIT) else begin
        stop_with_error("Done never came up while polling STATUS");
      end
      wb_read(`DOT_REG_STATUS, status);
    end
  endtask

  // Completed vector, count and result both checked
  task automatic finish_and_check(input int n);
    logic [31:0] status;
    logic [31:0] result;
    wait_done(status);
    check_value("STATUS.count", n, status[16 +: `DOT_LEN_W]);
    wb_read(`DOT_REG_RESULT, result);
    check_value("RESULT", model_sum(n), result);
  endtask

  task automatic run_vector(input int n);
    start_vector(n);
    for (int i = 0; i < n; i++) begin
      send_elem(i);
    end
    finish_and_check(n);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    int          len;
    void'($urandom(32'h054d_fbb5));
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_i = '0;
    sel   = 4'h0;
    RST   = 1'b1;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Idle state after reset
    wb_read(`DOT_REG_STATUS, rd);
    check_value("STATUS.done", 0, rd[0]);
    check_value("STATUS.count", 0, rd[16 +: `DOT_LEN_W]);
    wb_read(`DOT_REG_RESULT, rd);
    check_value("RESULT", 0, rd);

    // Random lengths and full-range elements
    for (int t = 0; t < NUM_RAND; t++) begin
      len = ($urandom % MAX_LEN) + 1;
      fill_random(len);
      run_vector(len);
    end
    // Largest products, the sum wraps past 2^32
    for (int i = 0; i < 6; i++) begin
      vec_a[i] = 16'h8000;
      vec_b[i] = 16'h8000;
    end
    run_vector(6);

    // Short odd and even lengths, 1 uses the even lane only
    for (int k = 0; k < 5; k++) begin
      len = (k == 4) ? 7 : k + 1;
      fill_random(len);
      run_vector(len);
    end

    // Length 0, then extra writes
    start_vector(0);
    finish_and_check(0);
    fill_random(2);
    send_elem(0);
    send_elem(1);
    finish_and_check(0);

    // Overrun past the length
    fill_random(8);
    start_vector(5);
    for (int i = 0; i < 8; i++) begin
      send_elem(i);
    end
    finish_and_check(5);
    send_elem(6);
    finish_and_check(5);

    // Restart in the middle of a vector
    fill_random(20);
    start_vector(20);
    for (int i = 0; i < 7; i++) begin
      send_elem(i);
    end
    fill_random(15);
    start_vector(15);
    wb_read(`DOT_REG_STATUS, rd);
    check_value("STATUS.done", 0, rd[0]);
    check_value("STATUS.count", 0, rd[16 +: `DOT_LEN_W]);
    for (int i = 0; i < 15; i++) begin
      send_elem(i);
    end
    finish_and_check(15);

    // Count tracks each accepted write, done stays low
    fill_random(12);
    start_vector(12);
    for (int i = 0; i < 12; i++) begin
      wb_read(`DOT_REG_STATUS, rd);
      check_value("STATUS.count", i, rd[16 +: `DOT_LEN_W]);
      check_value("STATUS.done", 0, rd[0]);
      send_elem(i);
    end
    finish_and_check(12);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/dot_pkg.sv
rtl/dot_wb_regs.sv
rtl/dot_mac_lane.sv
rtl/dot_combiner.sv
rtl/dot_top.sv
sim/dot_tb.sv
